// ==== source/seq_config.svh ====
// Sequencer sizing macros: instruction IDs, vector registers and unit queue depths

`ifndef SEQ_CONFIG_SVH
`define SEQ_CONFIG_SVH

// Instructions in flight, one ID each
`define SEQ_NR_VINSN 8

// Architectural vector registers
`define SEQ_NR_VREGS 32

// Per-unit instruction queue depths
`define SEQ_ALU_DEPTH   2
`define SEQ_MUL_DEPTH   2
`define SEQ_LOAD_DEPTH  1
`define SEQ_STORE_DEPTH 1
`define SEQ_SLIDE_DEPTH 1

`endif

// ==== source/seq_isa_pkg.sv ====
// Vector instruction set types: operation encoding, register index and slide check

`include "seq_config.svh"

package seq_isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operations
  ////////////////////////////////////////////////////////////////////////////

  // Decoded vector operations, grouped by target unit
  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VAND,
    VMUL,
    VMACC,
    VLE,
    VSE,
    VSLIDEUP,
    VSLIDEDOWN
  } vop_e;

  // Vector register index
  typedef logic [$clog2(`SEQ_NR_VREGS)-1:0] vreg_t;

  // Slides move data across elements and cannot be chained
  function automatic logic is_slide(vop_e op);
    return (op == VSLIDEUP) || (op == VSLIDEDOWN);
  endfunction

endpackage

// ==== source/seq_core_pkg.sv ====
// Sequencer bookkeeping types: instruction ID, ID mask, unit enum, unit mask, queue counter

`include "seq_config.svh"

package seq_core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction IDs
  ////////////////////////////////////////////////////////////////////////////

  // ID handed to each accepted instruction
  typedef logic [$clog2(`SEQ_NR_VINSN)-1:0] vid_t;

  // One bit per ID
  // Running set, hazard mask and done pulses all share this shape
  typedef logic [`SEQ_NR_VINSN-1:0] vid_mask_t;

  ////////////////////////////////////////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NrUnits = 5;

  // Enum value doubles as the bit position in unit_mask_t
  typedef enum logic [2:0] {
    UNIT_ALU,
    UNIT_MUL,
    UNIT_LOAD,
    UNIT_STORE,
    UNIT_SLIDE
  } unit_e;

  // One bit per unit
  typedef logic [NrUnits-1:0] unit_mask_t;

  // Instructions held by one unit, up to the deepest queue
  typedef logic [1:0] qcnt_t;

endpackage

// ==== source/vinsn_decoder.sv ====
// Operation decoder: target unit, unit mask and register read/write sets

module vinsn_decoder
  import seq_isa_pkg::*;
  import seq_core_pkg::*;
(
  input  vop_e       op_i,
  input  logic       use_vs1_i,
  input  logic       use_vs2_i,
  input  logic       use_vd_i,
  output unit_e      unit_o,
  output unit_mask_t unit_mask_o,
  output logic       rd_vs1_o,
  output logic       rd_vs2_o,
  output logic       rd_vd_o,
  output logic       wr_vd_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Unit selection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unit_o = UNIT_ALU;
    case (op_i)
      VADD, VSUB, VAND: unit_o = UNIT_ALU;
      VMUL, VMACC:      unit_o = UNIT_MUL;
      VLE:              unit_o = UNIT_LOAD;
      VSE:              unit_o = UNIT_STORE;
      VSLIDEUP, VSLIDEDOWN: begin
        unit_o = UNIT_SLIDE;
      end
      // Unused encodings fall back to the ALU
      default:          unit_o = UNIT_ALU;
    endcase
  end

  // Single target per operation
  assign unit_mask_o = unit_mask_t'(1) << unit_o;

  ////////////////////////////////////////////////////////////////////////////
  // Register use
  ////////////////////////////////////////////////////////////////////////////

  // Sources are read whenever flagged
  assign rd_vs1_o = use_vs1_i;
  assign rd_vs2_o = use_vs2_i;

  // Store data and the accumulator come from vd
  assign rd_vd_o = use_vd_i & ((op_i == VSE) | (op_i == VMACC));

  // Everything but a store writes its destination
  assign wr_vd_o = use_vd_i & (op_i != VSE);

endmodule

// ==== source/hazard_tracker.sv ====
// Per-register reader/writer lists and hazard mask of the incoming instruction

`include "seq_config.svh"

module hazard_tracker
  import seq_isa_pkg::*;
  import seq_core_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  vreg_t     vs1_i,
  input  vreg_t     vs2_i,
  input  vreg_t     vd_i,
  input  logic      rd_vs1_i,
  input  logic      rd_vs2_i,
  input  logic      rd_vd_i,
  input  logic      wr_vd_i,
  input  logic      accept_i,
  input  vid_t      accept_id_i,
  input  vid_mask_t running_i,
  output vid_mask_t hazard_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Access lists
  ////////////////////////////////////////////////////////////////////////////

  // Last reader and last writer of each register
  vid_t                     rd_vid_q [`SEQ_NR_VREGS];
  vid_t                     wr_vid_q [`SEQ_NR_VREGS];
  logic [`SEQ_NR_VREGS-1:0] rd_vld_q, rd_vld_d;
  logic [`SEQ_NR_VREGS-1:0] wr_vld_q, wr_vld_d;
  // Entries whose ID is still running
  logic [`SEQ_NR_VREGS-1:0] rd_live;
  logic [`SEQ_NR_VREGS-1:0] wr_live;

  // Entry dies as soon as its ID drops out of the running set
  for (genvar r = 0; r < `SEQ_NR_VREGS; r++) begin : gen_live
    assign rd_live[r] = rd_vld_q[r] & running_i[rd_vid_q[r]];
    assign wr_live[r] = wr_vld_q[r] & running_i[wr_vid_q[r]];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Hazard mask
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hazard_o = '0;
    // RAW on each source, vd included when it is read
    if (rd_vs1_i && wr_live[vs1_i]) hazard_o[wr_vid_q[vs1_i]] = 1'b1;
    if (rd_vs2_i && wr_live[vs2_i]) hazard_o[wr_vid_q[vs2_i]] = 1'b1;
    if (rd_vd_i && wr_live[vd_i]) hazard_o[wr_vid_q[vd_i]] = 1'b1;
    // WAR and WAW on the destination
    if (wr_vd_i) begin
      if (rd_live[vd_i]) hazard_o[rd_vid_q[vd_i]] = 1'b1;
      if (wr_live[vd_i]) hazard_o[wr_vid_q[vd_i]] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // List update
  ////////////////////////////////////////////////////////////////////////////

  // Drop dead entries, then record the accepted instruction
  always_comb begin
    rd_vld_d = rd_live;
    wr_vld_d = wr_live;
    if (accept_i) begin
      if (rd_vs1_i) rd_vld_d[vs1_i] = 1'b1;
      if (rd_vs2_i) rd_vld_d[vs2_i] = 1'b1;
      if (rd_vd_i) rd_vld_d[vd_i] = 1'b1;
      if (wr_vd_i) wr_vld_d[vd_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_vld_q <= '0;
      wr_vld_q <= '0;
    end else begin
      rd_vld_q <= rd_vld_d;
      wr_vld_q <= wr_vld_d;
    end
  end

  // IDs only matter while the matching valid bit is set
  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      if (rd_vs1_i) rd_vid_q[vs1_i] <= accept_id_i;
      if (rd_vs2_i) rd_vid_q[vs2_i] <= accept_id_i;
      if (rd_vd_i) rd_vid_q[vd_i] <= accept_id_i;
      if (wr_vd_i) wr_vid_q[vd_i] <= accept_id_i;
    end
  end

endmodule

// ==== source/vinsn_issue.sv ====
// Issue stage: free ID selection, stall decision, held unit request and dispatcher ready

`include "seq_config.svh"

module vinsn_issue
  import seq_isa_pkg::*;
  import seq_core_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // Dispatcher handshake
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  vop_e       op_i,
  // From decode, hazard tracking and completion
  input  unit_e      unit_i,
  input  vid_mask_t  hazard_i,
  input  vid_mask_t  running_i,
  input  unit_mask_t unit_ready_i,
  input  unit_mask_t unit_mask_i,
  // Accept strobe towards the lists and counters
  output logic       accept_o,
  output vid_t       accept_id_o,
  // Unit request
  output logic       pe_req_valid_o,
  input  logic       pe_req_ready_i,
  output vid_t       pe_req_id_o,
  output vop_e       pe_req_op_o,
  output unit_e      pe_req_unit_o,
  output vid_mask_t  pe_req_hazard_o
);

  ////////////////////////////////////////////////////////////////////////////
  // ID selection
  ////////////////////////////////////////////////////////////////////////////

  vid_t free_id;
  logic id_free;

  // Scan downwards so the lowest free ID wins
  always_comb begin
    free_id = '0;
    id_free = 1'b0;
    for (int i = `SEQ_NR_VINSN - 1; i >= 0; i--) begin
      if (!running_i[i]) begin
        free_id = vid_t'(i);
        id_free = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stall decision
  ////////////////////////////////////////////////////////////////////////////

  logic held_blocked;
  logic unit_ok;
  logic slide_stall;

  // Request on the unit side not yet taken
  assign held_blocked = pe_req_valid_o & ~pe_req_ready_i;

  // Every targeted unit has queue room
  assign unit_ok = ~|(unit_mask_i & ~unit_ready_i);

  // Slides wait for all their dependencies to retire
  assign slide_stall = is_slide(op_i) & (|hazard_i);

  assign req_ready_o = ~held_blocked & id_free & unit_ok & ~slide_stall;

  assign accept_o    = req_valid_i & req_ready_o;
  assign accept_id_o = free_id;

  ////////////////////////////////////////////////////////////////////////////
  // Unit request register
  ////////////////////////////////////////////////////////////////////////////

  // Valid drops once taken unless a new instruction replaces it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else if (accept_o) begin
      pe_req_valid_o <= 1'b1;
    end else if (pe_req_ready_i) begin
      pe_req_valid_o <= 1'b0;
    end
  end

  // Fields load only on accept, so they hold while blocked
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      pe_req_id_o     <= free_id;
      pe_req_op_o     <= op_i;
      pe_req_unit_o   <= unit_i;
      pe_req_hazard_o <= hazard_i;
    end
  end

endmodule

// ==== source/vinsn_completion.sv ====
// Completion tracking: running ID set, per-unit queue counters, unit readiness, idle

`include "seq_config.svh"

module vinsn_completion
  import seq_core_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     accept_i,
  input  vid_t                     accept_id_i,
  input  unit_mask_t               unit_mask_i,
  // One done mask per unit, indexed by unit_e
  input  vid_mask_t [NrUnits-1:0]  unit_done_i,
  output vid_mask_t                running_o,
  output unit_mask_t               unit_ready_o,
  output logic                     idle_o
);

  // Queue depth per unit, in unit_e order
  localparam int unsigned QueueDepth [NrUnits] = '{
    `SEQ_ALU_DEPTH,
    `SEQ_MUL_DEPTH,
    `SEQ_LOAD_DEPTH,
    `SEQ_STORE_DEPTH,
    `SEQ_SLIDE_DEPTH
  };

  ////////////////////////////////////////////////////////////////////////////
  // Running set
  ////////////////////////////////////////////////////////////////////////////

  vid_mask_t running_q;
  vid_mask_t done_any;

  // Any unit may retire any ID
  always_comb begin
    done_any = '0;
    for (int u = 0; u < NrUnits; u++) begin
      done_any |= unit_done_i[u];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      if (accept_i) running_q[accept_id_i] <= 1'b1;
      // Accepted ID is free, so it never collides with a done bit
      for (int i = 0; i < `SEQ_NR_VINSN; i++) begin
        if (done_any[i]) running_q[i] <= 1'b0;
      end
    end
  end

  assign running_o = running_q;
  assign idle_o    = ~|running_q;

  ////////////////////////////////////////////////////////////////////////////
  // Queue counters
  ////////////////////////////////////////////////////////////////////////////

  qcnt_t [NrUnits-1:0] cnt_q;

  for (genvar u = 0; u < NrUnits; u++) begin : gen_cnt
    logic up;
    logic down;

    assign up   = accept_i & unit_mask_i[u];
    assign down = |unit_done_i[u];

    // Issue and retire in one cycle cancel out
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[u] <= '0;
      end else if (up && !down) begin
        cnt_q[u] <= cnt_q[u] + qcnt_t'(1);
      end else if (down && !up) begin
        cnt_q[u] <= cnt_q[u] - qcnt_t'(1);
      end
    end

    assign unit_ready_o[u] = cnt_q[u] < qcnt_t'(QueueDepth[u]);
  end

endmodule

// ==== source/vinsn_sequencer.sv ====
// Vector instruction sequencer top: decode, hazard tracking, issue and completion

module vinsn_sequencer
  import seq_isa_pkg::*;
  import seq_core_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Dispatcher
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  vop_e                    req_op_i,
  input  vreg_t                   req_vs1_i,
  input  logic                    req_use_vs1_i,
  input  vreg_t                   req_vs2_i,
  input  logic                    req_use_vs2_i,
  input  vreg_t                   req_vd_i,
  input  logic                    req_use_vd_i,
  // Unit request
  output logic                    pe_req_valid_o,
  input  logic                    pe_req_ready_i,
  output vid_t                    pe_req_id_o,
  output vop_e                    pe_req_op_o,
  output unit_e                   pe_req_unit_o,
  output vid_mask_t               pe_req_hazard_o,
  // Completion
  input  vid_mask_t [NrUnits-1:0] unit_done_i,
  output logic                    idle_o
);

  unit_e      unit;
  unit_mask_t unit_mask;
  logic       rd_vs1, rd_vs2, rd_vd, wr_vd;
  vid_mask_t  hazard;
  vid_mask_t  running;
  unit_mask_t unit_ready;
  logic       accept;
  vid_t       accept_id;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  vinsn_decoder u_decoder (
    .op_i        (req_op_i),
    .use_vs1_i   (req_use_vs1_i),
    .use_vs2_i   (req_use_vs2_i),
    .use_vd_i    (req_use_vd_i),
    .unit_o      (unit),
    .unit_mask_o (unit_mask),
    .rd_vs1_o    (rd_vs1),
    .rd_vs2_o    (rd_vs2),
    .rd_vd_o     (rd_vd),
    .wr_vd_o     (wr_vd)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////////////////////

  hazard_tracker u_hazard (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .vs1_i       (req_vs1_i),
    .vs2_i       (req_vs2_i),
    .vd_i        (req_vd_i),
    .rd_vs1_i    (rd_vs1),
    .rd_vs2_i    (rd_vs2),
    .rd_vd_i     (rd_vd),
    .wr_vd_i     (wr_vd),
    .accept_i    (accept),
    .accept_id_i (accept_id),
    .running_i   (running),
    .hazard_o    (hazard)
  );

  vinsn_issue u_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .op_i            (req_op_i),
    .unit_i          (unit),
    .hazard_i        (hazard),
    .running_i       (running),
    .unit_ready_i    (unit_ready),
    .unit_mask_i     (unit_mask),
    .accept_o        (accept),
    .accept_id_o     (accept_id),
    .pe_req_valid_o  (pe_req_valid_o),
    .pe_req_ready_i  (pe_req_ready_i),
    .pe_req_id_o     (pe_req_id_o),
    .pe_req_op_o     (pe_req_op_o),
    .pe_req_unit_o   (pe_req_unit_o),
    .pe_req_hazard_o (pe_req_hazard_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////////////////////

  vinsn_completion u_completion (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .accept_i     (accept),
    .accept_id_i  (accept_id),
    .unit_mask_i  (unit_mask),
    .unit_done_i  (unit_done_i),
    .running_o    (running),
    .unit_ready_o (unit_ready),
    .idle_o       (idle_o)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock and reset generator

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 100,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== testbench/tb_seq_assertions.sv ====
// Concurrent handshake assertions for the sequencer top level, with their bind

module tb_seq_assertions
  import seq_isa_pkg::*;
  import seq_core_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input logic      req_ready_i,
  input logic      pe_req_valid_i,
  input logic      pe_req_ready_i,
  input vid_t      pe_req_id_i,
  input vop_e      pe_req_op_i,
  input unit_e     pe_req_unit_i,
  input vid_mask_t pe_req_hazard_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Blocked unit request keeps valid and every field
  held_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_i && !pe_req_ready_i |=> pe_req_valid_i && $stable(pe_req_id_i) &&
      $stable(pe_req_op_i) && $stable(pe_req_unit_i) && $stable(pe_req_hazard_i))
    else $error("unit request changed while blocked");

  // No request leaves during reset
  reset_quiet_a : assert property (@(posedge clk_i) !rst_ni |-> !pe_req_valid_i)
    else $error("unit request valid during reset");

  // Dispatcher sees back-pressure from a blocked request
  backpressure_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_i && !pe_req_ready_i |-> !req_ready_i)
    else $error("dispatcher ready while unit request blocked");

endmodule

bind vinsn_sequencer tb_seq_assertions u_seq_assertions (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .req_ready_i     (req_ready_o),
  .pe_req_valid_i  (pe_req_valid_o),
  .pe_req_ready_i  (pe_req_ready_i),
  .pe_req_id_i     (pe_req_id_o),
  .pe_req_op_i     (pe_req_op_o),
  .pe_req_unit_i   (pe_req_unit_o),
  .pe_req_hazard_i (pe_req_hazard_o)
);

// ==== testbench/tb_sequencer.sv ====
// Sequencer testbench top: pattern reader, reference model, compare tasks and DUT

`include "seq_config.svh"

module tb_sequencer
  import seq_isa_pkg::*;
  import seq_core_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned ClkPeriod = 100;
  localparam int Timeout = 50;
  localparam string PatternFile = "testbench/seq_patterns.txt";

  logic clk;
  logic rst_n;
  logic req_valid;
  logic req_ready;
  vop_e req_op;
  vreg_t req_vs1;
  vreg_t req_vs2;
  vreg_t req_vd;
  logic req_use_vs1;
  logic req_use_vs2;
  logic req_use_vd;
  logic pe_req_valid;
  logic pe_req_ready;
  vid_t pe_req_id;
  vop_e pe_req_op;
  unit_e pe_req_unit;
  vid_mask_t pe_req_hazard;
  vid_mask_t [NrUnits-1:0] unit_done;
  logic idle;

  // Fields of the current pattern line
  int pat_op;
  int pat_vs1;
  int pat_u1;
  int pat_vs2;
  int pat_u2;
  int pat_vd;
  int pat_ud;
  int arg_a;
  int arg_b;

  // Reference model of the running set, register lists and unit occupancy
  vid_mask_t m_running;
  vid_t m_wr_id [`SEQ_NR_VREGS];
  vid_t m_rd_id [`SEQ_NR_VREGS];
  logic [`SEQ_NR_VREGS-1:0] m_wr_vld;
  logic [`SEQ_NR_VREGS-1:0] m_rd_vld;
  int m_cnt [NrUnits];
  logic m_held;

  tb_clock_gen #(.PeriodNs(ClkPeriod), .ResetCycles(3)) u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  vinsn_sequencer u_vinsn_sequencer (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .req_op_i        (req_op),
    .req_vs1_i       (req_vs1),
    .req_use_vs1_i   (req_use_vs1),
    .req_vs2_i       (req_vs2),
    .req_use_vs2_i   (req_use_vs2),
    .req_vd_i        (req_vd),
    .req_use_vd_i    (req_use_vd),
    .pe_req_valid_o  (pe_req_valid),
    .pe_req_ready_i  (pe_req_ready),
    .pe_req_id_o     (pe_req_id),
    .pe_req_op_o     (pe_req_op),
    .pe_req_unit_o   (pe_req_unit),
    .pe_req_hazard_o (pe_req_hazard),
    .unit_done_i     (unit_done),
    .idle_o          (idle)
  );

  //////////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_id(input vid_t actual, input vid_t expected, input string what);
    if (actual !== expected) begin
      $display("error %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_hazard(input vid_mask_t actual, input vid_mask_t expected,
                              input string what);
    if (actual !== expected) begin
      $display("error %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_unit(input unit_e actual, input unit_e expected, input string what);
    if (actual !== expected) begin
      $display("error %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_op(input vop_e actual, input vop_e expected, input string what);
    if (actual !== expected) begin
      $display("error %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("error %0t ns: %s is %b, expected %b", $time, what, actual, expected);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////////

  function automatic unit_e unit_of(vop_e op);
    case (op)
      VMUL, VMACC:          return UNIT_MUL;
      VLE:                  return UNIT_LOAD;
      VSE:                  return UNIT_STORE;
      VSLIDEUP, VSLIDEDOWN: return UNIT_SLIDE;
      default:              return UNIT_ALU;
    endcase
  endfunction

  function automatic int depth_of(unit_e u);
    case (u)
      UNIT_ALU:   return `SEQ_ALU_DEPTH;
      UNIT_MUL:   return `SEQ_MUL_DEPTH;
      UNIT_LOAD:  return `SEQ_LOAD_DEPTH;
      UNIT_STORE: return `SEQ_STORE_DEPTH;
      default:    return `SEQ_SLIDE_DEPTH;
    endcase
  endfunction

  // Expected ID, hazard mask and stall for the current pattern
  task automatic model_expect(output vid_t id, output vid_mask_t haz, output logic stall);
    vop_e op;
    logic rd_vd;
    logic wr_vd;
    logic found;
    op = vop_e'(pat_op);
    rd_vd = (pat_ud != 0) && (op == VSE || op == VMACC);
    wr_vd = (pat_ud != 0) && (op != VSE);
    haz = '0;
    // RAW against the last writer of each source
    if (pat_u1 != 0 && m_wr_vld[pat_vs1]) haz[m_wr_id[pat_vs1]] = 1'b1;
    if (pat_u2 != 0 && m_wr_vld[pat_vs2]) haz[m_wr_id[pat_vs2]] = 1'b1;
    if (rd_vd && m_wr_vld[pat_vd]) haz[m_wr_id[pat_vd]] = 1'b1;
    // WAR and WAW on the destination
    if (wr_vd && m_rd_vld[pat_vd]) haz[m_rd_id[pat_vd]] = 1'b1;
    if (wr_vd && m_wr_vld[pat_vd]) haz[m_wr_id[pat_vd]] = 1'b1;
    id = '0;
    found = 1'b0;
    for (int i = 0; i < `SEQ_NR_VINSN; i++) begin
      if (!found && !m_running[i]) begin
        id = vid_t'(i);
        found = 1'b1;
      end
    end
    stall = !found || (m_cnt[int'(unit_of(op))] >= depth_of(unit_of(op))) ||
            ((op == VSLIDEUP || op == VSLIDEDOWN) && (haz != '0)) ||
            (m_held && !pe_req_ready);
  endtask

  task automatic model_accept(input vid_t id);
    vop_e op;
    op = vop_e'(pat_op);
    m_running[id] = 1'b1;
    m_cnt[int'(unit_of(op))]++;
    m_held = !pe_req_ready;
    if (pat_u1 != 0) begin
      m_rd_vld[pat_vs1] = 1'b1;
      m_rd_id[pat_vs1] = id;
    end
    if (pat_u2 != 0) begin
      m_rd_vld[pat_vs2] = 1'b1;
      m_rd_id[pat_vs2] = id;
    end
    if (pat_ud != 0 && (op == VSE || op == VMACC)) begin
      m_rd_vld[pat_vd] = 1'b1;
      m_rd_id[pat_vd] = id;
    end
    if (pat_ud != 0 && op != VSE) begin
      m_wr_vld[pat_vd] = 1'b1;
      m_wr_id[pat_vd] = id;
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Pattern commands that start and end on a falling edge
  //////////////////////////////////////////////////////////////////////////

  task automatic drive_pattern();
    req_op = vop_e'(pat_op);
    req_vs1 = vreg_t'(pat_vs1);
    req_use_vs1 = (pat_u1 != 0);
    req_vs2 = vreg_t'(pat_vs2);
    req_use_vs2 = (pat_u2 != 0);
    req_vd = vreg_t'(pat_vd);
    req_use_vd = (pat_ud != 0);
    req_valid = 1'b1;
  endtask

  task automatic issue_insn(input vid_t exp_id, input vid_mask_t exp_haz);
    vid_t m_id;
    vid_mask_t m_haz;
    logic m_stall;
    int waited;
    model_expect(m_id, m_haz, m_stall);
    check_id(m_id, exp_id, "model id");
    check_hazard(m_haz, exp_haz, "model hazard");
    check_flag(m_stall, 1'b0, "model stall");
    drive_pattern();
    waited = 0;
    // Ready is sampled mid low phase, where it is settled
    #(ClkPeriod / 4);
    while (req_ready !== 1'b1) begin
      if (waited >= Timeout) begin
        $display("timeout: instruction at %0t ns was never accepted", $time);
        abort_run();
      end
      @(negedge clk);
      #(ClkPeriod / 4);
      waited++;
    end
    @(negedge clk);
    req_valid = 1'b0;
    check_flag(pe_req_valid, 1'b1, "pe_req_valid_o");
    check_id(pe_req_id, exp_id, "pe_req_id_o");
    check_hazard(pe_req_hazard, exp_haz, "pe_req_hazard_o");
    check_unit(pe_req_unit, unit_of(vop_e'(pat_op)), "pe_req_unit_o");
    check_op(pe_req_op, vop_e'(pat_op), "pe_req_op_o");
    check_flag(idle, 1'b0, "idle_o while running");
    model_accept(exp_id);
  endtask

  // Instruction stays presented and must not be taken
  task automatic hold_insn(input int cycles);
    vid_t m_id;
    vid_mask_t m_haz;
    logic m_stall;
    model_expect(m_id, m_haz, m_stall);
    check_flag(m_stall, 1'b1, "model stall");
    drive_pattern();
    for (int c = 0; c < cycles; c++) begin
      #(ClkPeriod / 4);
      check_flag(req_ready, 1'b0, "req_ready_o while stalled");
      @(negedge clk);
    end
  endtask

  task automatic pulse_done(input int unit, input int id);
    check_flag(m_running[id], 1'b1, "model running bit");
    unit_done[unit][id] = 1'b1;
    @(negedge clk);
    unit_done = '0;
    m_running[id] = 1'b0;
    m_cnt[unit]--;
    // Retired ID leaves every list
    for (int r = 0; r < `SEQ_NR_VREGS; r++) begin
      if (m_wr_vld[r] && m_wr_id[r] == vid_t'(id)) m_wr_vld[r] = 1'b0;
      if (m_rd_vld[r] && m_rd_id[r] == vid_t'(id)) m_rd_vld[r] = 1'b0;
    end
  endtask

  // Lowering ready first lets the pending request drain
  task automatic set_pe_ready(input int value);
    int waited;
    waited = 0;
    while (value == 0 && pe_req_valid !== 1'b0) begin
      if (waited >= Timeout) begin
        $display("timeout: unit request never drained");
        abort_run();
      end
      @(negedge clk);
      waited++;
    end
    pe_req_ready = (value != 0);
    if (value != 0) m_held = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (idle !== 1'b1) begin
      if (waited >= Timeout) begin
        $display("timeout: sequencer never went idle");
        abort_run();
      end
      @(negedge clk);
      waited++;
    end
    check_hazard(m_running, '0, "model running set");
  endtask

  task automatic run_command(input string line);
    byte cmd;
    string args;
    int n;
    cmd = line.getc(0);
    args = line.substr(1, line.len() - 1);
    n = 0;
    case (cmd)
      "I": begin
        n = $sscanf(args, "%d %d %d %d %d %d %d %d %h", pat_op, pat_vs1, pat_u1,
                    pat_vs2, pat_u2, pat_vd, pat_ud, arg_a, arg_b);
        if (n == 9) issue_insn(vid_t'(arg_a), vid_mask_t'(arg_b));
      end
      "H": begin
        n = $sscanf(args, "%d %d %d %d %d %d %d %d", pat_op, pat_vs1, pat_u1,
                    pat_vs2, pat_u2, pat_vd, pat_ud, arg_a);
        if (n == 8) hold_insn(arg_a);
      end
      "D": begin
        n = $sscanf(args, "%d %d", arg_a, arg_b);
        if (n == 2) pulse_done(arg_a, arg_b);
      end
      "R": begin
        n = $sscanf(args, "%d", arg_a);
        if (n == 1) set_pe_ready(arg_a);
      end
      "W": begin
        n = 1;
        wait_idle();
      end
      default: n = 0;
    endcase
    if (n == 0) begin
      $display("malformed pattern line: %s", line);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    int fd;
    int n;
    int waited;
    string line;
    req_valid = 1'b0;
    req_op = VADD;
    req_vs1 = '0;
    req_vs2 = '0;
    req_vd = '0;
    req_use_vs1 = 1'b0;
    req_use_vs2 = 1'b0;
    req_use_vd = 1'b0;
    pe_req_ready = 1'b1;
    unit_done = '0;
    m_running = '0;
    m_wr_vld = '0;
    m_rd_vld = '0;
    m_held = 1'b0;
    for (int u = 0; u < NrUnits; u++) m_cnt[u] = 0;

    waited = 0;
    while (rst_n !== 1'b1) begin
      if (waited >= Timeout) begin
        $display("timeout: reset was never released");
        abort_run();
      end
      @(negedge clk);
      waited++;
    end

    // State right after reset
    check_flag(idle, 1'b1, "idle_o after reset");
    check_flag(pe_req_valid, 1'b0, "pe_req_valid_o after reset");
    check_flag(req_ready, 1'b1, "req_ready_o after reset");

    fd = $fopen(PatternFile, "r");
    if (fd == 0) begin
      $display("could not open pattern file %s", PatternFile);
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") run_command(line);
    end
    $fclose(fd);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/seq_isa_pkg.sv
source/seq_core_pkg.sv
source/vinsn_decoder.sv
source/hazard_tracker.sv
source/vinsn_issue.sv
source/vinsn_completion.sv
source/vinsn_sequencer.sv
testbench/tb_clock_gen.sv
testbench/tb_seq_assertions.sv
testbench/tb_sequencer.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_sequencer -f vlog.f -o tb_sequencer_sim &&
./obj_dir/tb_sequencer_sim ||
{ echo "simulation did not pass"; exit 1; }

// ==== testbench/seq_patterns.txt ====
# I op vs1 use1 vs2 use2 vd usevd exp_id exp_hazard(hex) | H same fields then stall cycles
# D unit id | R pe_req_ready | W wait idle | ops VADD..VSLIDEDOWN = 0..8, units ALU..SLIDE = 0..4
I 5 0 0 0 0 1 1 0 00  # vle v1
I 0 2 1 3 1 4 1 1 00  # vadd v4
I 3 5 1 6 1 7 1 2 00  # vmul v7
I 1 1 1 4 1 8 1 3 03  # vsub v8 raw on ids 0 and 1
H 2 9 1 10 1 11 1 3   # vand held by full alu queue
D 0 1
I 2 9 1 10 1 11 1 1 00
I 3 5 1 6 1 1 1 4 09  # vmul v1 war on 3, waw on 0
D 2 0
I 5 0 0 0 0 7 1 0 04  # vle v7 waw on 2
R 0
I 6 0 0 0 0 8 1 5 08  # vse v8 raw on 3, left blocked
H 7 0 0 20 1 13 1 3   # vslideup held by blocked request
R 1
I 7 0 0 20 1 13 1 6 00
D 4 6
H 8 0 0 7 1 14 1 3    # vslidedown waits for id 0
D 2 0
I 8 0 0 7 1 14 1 0 00
D 4 0
D 0 1
D 1 2
D 0 3
D 1 4
D 3 5
W
I 0 1 1 2 1 3 1 0 00  # id 0 again
D 0 0
W
